/* rtl/desc_stream_if.sv */
`timescale 1ns/1ps

// Byte stream with a valid/ready handshake
interface desc_stream_if;

  logic       valid;
  logic       ready;
  logic       last;
  logic [7:0] data;

  modport source (output valid, last, data, input ready);

  modport sink (input valid, last, data, output ready);

endinterface

/* rtl/descriptor_reader.sv */
`timescale 1ns/1ps

module descriptor_reader (
  input  logic                                clock,
  input  logic                                reset,
  input  logic                                load_i,
  input  logic                                abort_i,
  input  logic [usb_ep0_pkg::DESC_ADDR_W-1:0] start_addr_i,
  input  logic [7:0]                          desc_len_i,
  input  logic [15:0]                         max_len_i,
  desc_stream_if.source                       out
);

  logic [usb_ep0_pkg::DESC_ADDR_W-1:0] rd_ptr;
  logic [7:0]                          remaining;
  logic [7:0]                          load_count;
  logic                                byte_taken;

  // Host may ask for fewer bytes than the descriptor holds
  assign load_count = (max_len_i < {8'd0, desc_len_i}) ? max_len_i[7:0] : desc_len_i;

  assign byte_taken = out.valid && out.ready;

  always_ff @(posedge clock) begin
    if (reset) begin
      remaining <= 8'd0;
    end else if (abort_i) begin
      remaining <= 8'd0;
    end else if (load_i) begin
      remaining <= load_count;
    end else if (byte_taken) begin
      remaining <= remaining - 8'd1;
    end
  end

  always_ff @(posedge clock) begin
    if (load_i) begin
      rd_ptr <= start_addr_i;
    end else if (byte_taken) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

  assign out.valid = (remaining != 8'd0);
  assign out.last  = (remaining == 8'd1);

  // The pointer steps one past the ROM end after the final serial byte
  assign out.data = (rd_ptr < usb_ep0_pkg::DESC_ROM_SIZE) ? usb_ep0_pkg::DESC_ROM[rd_ptr]
                                                          : 8'h00;

endmodule

/* rtl/ep0_request_handler.sv */
`timescale 1ns/1ps

module ep0_request_handler (
  input  logic          clock,
  input  logic          reset,
  input  logic          select_i,
  setup_req_if.sink     req,
  desc_stream_if.source desc,
  output logic          accept_o,
  output logic          error_o,
  output logic          configured_o,
  output logic [6:0]    usb_addr_o,
  output logic [7:0]    usb_conf_o
);

  usb_ep0_pkg::req_kind_e              req_kind;
  usb_ep0_pkg::pipe_state_e            state;
  logic                                handle_req;
  logic                                is_get;
  logic                                take_req;
  logic [usb_ep0_pkg::DESC_ADDR_W-1:0] desc_start;
  logic [7:0]                          desc_len;

  // Only standard requests addressed to the device are decoded
  assign handle_req = (req.req_type[6:5] == usb_ep0_pkg::REQ_TYPE_STANDARD) &&
                      (req.req_type[4:0] == usb_ep0_pkg::REQ_RCPT_DEVICE);

  always_comb begin
    req_kind = usb_ep0_pkg::REQ_NONE;
    if (handle_req) begin
      case (req.req_code)
        usb_ep0_pkg::REQ_CODE_GET_DESCRIPTOR: begin
          case (req.req_value[15:8])
            usb_ep0_pkg::DESC_TYPE_DEVICE: req_kind = usb_ep0_pkg::REQ_GET_DEV;
            usb_ep0_pkg::DESC_TYPE_CONFIG: req_kind = usb_ep0_pkg::REQ_GET_CONF;
            usb_ep0_pkg::DESC_TYPE_STRING: begin
              if (req.req_value[7:0] < usb_ep0_pkg::NUM_STRINGS) begin
                req_kind = usb_ep0_pkg::REQ_GET_STR;
              end
            end
            default: ;
          endcase
        end
        usb_ep0_pkg::REQ_CODE_SET_ADDRESS:       req_kind = usb_ep0_pkg::REQ_SET_ADDR;
        usb_ep0_pkg::REQ_CODE_SET_CONFIGURATION: req_kind = usb_ep0_pkg::REQ_SET_CONF;
        default: ;
      endcase
    end
  end

  assign is_get = (req_kind == usb_ep0_pkg::REQ_GET_DEV) ||
                  (req_kind == usb_ep0_pkg::REQ_GET_CONF) ||
                  (req_kind == usb_ep0_pkg::REQ_GET_STR);

  // A new request is taken only from the idle pipe
  assign take_req = select_i && req.start && (state == usb_ep0_pkg::PIPE_IDLE);

  // ROM slice for the requested descriptor
  always_comb begin
    desc_start = usb_ep0_pkg::DESC_START_DEV;
    desc_len   = usb_ep0_pkg::DESC_LEN_DEV;
    if (req_kind == usb_ep0_pkg::REQ_GET_CONF) begin
      desc_start = usb_ep0_pkg::DESC_START_CONF;
      desc_len   = usb_ep0_pkg::DESC_LEN_CONF;
    end else if (req_kind == usb_ep0_pkg::REQ_GET_STR) begin
      case (req.req_value[1:0])
        2'd0: begin
          desc_start = usb_ep0_pkg::DESC_START_STR0;
          desc_len   = usb_ep0_pkg::DESC_LEN_STR0;
        end
        2'd1: begin
          desc_start = usb_ep0_pkg::DESC_START_STR1;
          desc_len   = usb_ep0_pkg::DESC_LEN_STR1;
        end
        2'd2: begin
          desc_start = usb_ep0_pkg::DESC_START_STR2;
          desc_len   = usb_ep0_pkg::DESC_LEN_STR2;
        end
        default: begin
          desc_start = usb_ep0_pkg::DESC_START_STR3;
          desc_len   = usb_ep0_pkg::DESC_LEN_STR3;
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state        <= usb_ep0_pkg::PIPE_IDLE;
      accept_o     <= 1'b0;
      error_o      <= 1'b0;
      configured_o <= 1'b0;
      usb_addr_o   <= 7'd0;
      usb_conf_o   <= 8'd0;
    end else if (take_req) begin
      accept_o <= (req_kind != usb_ep0_pkg::REQ_NONE);
      error_o  <= (req_kind == usb_ep0_pkg::REQ_NONE);
      case (req_kind)
        usb_ep0_pkg::REQ_SET_ADDR: begin
          usb_addr_o <= req.req_value[6:0];
          state      <= usb_ep0_pkg::PIPE_SET_ADDR;
        end
        usb_ep0_pkg::REQ_SET_CONF: begin
          usb_conf_o   <= req.req_value[7:0];
          // Configuration value 0 returns the device to the addressed state
          configured_o <= (req.req_value[7:0] != 8'd0);
          state        <= usb_ep0_pkg::PIPE_SET_CONF;
        end
        usb_ep0_pkg::REQ_NONE: ;
        default: state <= usb_ep0_pkg::PIPE_GET_DESC;
      endcase
    end else if (!select_i) begin
      accept_o <= 1'b0;
      error_o  <= 1'b0;
      state    <= usb_ep0_pkg::PIPE_IDLE;
    end
  end

  descriptor_reader reader_i (
    .clock       (clock),
    .reset       (reset),
    .load_i      (take_req && is_get),
    .abort_i     (!select_i),
    .start_addr_i(desc_start),
    .desc_len_i  (desc_len),
    .max_len_i   (req.req_length),
    .out         (desc)
  );

endmodule

/* rtl/setup_packet_capture.sv */
`timescale 1ns/1ps

module setup_packet_capture (
  input  logic       clock,
  input  logic       reset,
  input  logic       setup_valid_i,
  input  logic [7:0] setup_data_i,
  setup_req_if.source req
);

  logic [2:0]  byte_cnt;
  logic [7:0]  stage_type;
  logic [7:0]  stage_code;
  logic [15:0] stage_value;
  logic [7:0]  stage_length_lo;

  // Byte position within the packet and the start strobe
  always_ff @(posedge clock) begin
    if (reset) begin
      byte_cnt  <= 3'd0;
      req.start <= 1'b0;
    end else begin
      req.start <= setup_valid_i && (byte_cnt == 3'd7);
      if (setup_valid_i) begin
        byte_cnt <= byte_cnt + 3'd1;
      end
    end
  end

  // Bytes are staged so the published fields only change once per packet
  always_ff @(posedge clock) begin
    if (setup_valid_i) begin
      case (byte_cnt)
        3'd0: stage_type <= setup_data_i;
        3'd1: stage_code <= setup_data_i;
        3'd2: stage_value[7:0] <= setup_data_i;
        3'd3: stage_value[15:8] <= setup_data_i;
        // wIndex is not used by any supported request
        3'd4, 3'd5: ;
        3'd6: stage_length_lo <= setup_data_i;
        3'd7: begin
          req.req_type   <= stage_type;
          req.req_code   <= stage_code;
          req.req_value  <= stage_value;
          req.req_length <= {setup_data_i, stage_length_lo};
        end
        default: ;
      endcase
    end
  end

endmodule

/* rtl/setup_req_if.sv */
`timescale 1ns/1ps

// Request fields from the SETUP capture stage
interface setup_req_if;

  logic [7:0]  req_type;
  logic [7:0]  req_code;
  logic [15:0] req_value;
  logic [15:0] req_length;
  logic        start;

  modport source (
    output req_type, req_code, req_value, req_length, start
  );

  modport sink (
    input req_type, req_code, req_value, req_length, start
  );

endinterface

/* rtl/usb_ep0_ctrl.sv */
`timescale 1ns/1ps

module usb_ep0_ctrl (
  input  logic       clock,
  input  logic       reset,
  input  logic       setup_valid_i,
  input  logic [7:0] setup_data_i,
  input  logic       select_i,
  output logic       accept_o,
  output logic       error_o,
  output logic       configured_o,
  output logic [6:0] usb_addr_o,
  output logic [7:0] usb_conf_o,
  output logic       m_tvalid_o,
  input  logic       m_tready_i,
  output logic       m_tlast_o,
  output logic [7:0] m_tdata_o
);

  setup_req_if   setup_bus ();
  desc_stream_if desc_bus ();

  setup_packet_capture capture_i (
    .clock        (clock),
    .reset        (reset),
    .setup_valid_i(setup_valid_i),
    .setup_data_i (setup_data_i),
    .req          (setup_bus.source)
  );

  ep0_request_handler handler_i (
    .clock       (clock),
    .reset       (reset),
    .select_i    (select_i),
    .req         (setup_bus.sink),
    .desc        (desc_bus.source),
    .accept_o    (accept_o),
    .error_o     (error_o),
    .configured_o(configured_o),
    .usb_addr_o  (usb_addr_o),
    .usb_conf_o  (usb_conf_o)
  );

  // Descriptor stream out to the host-side packetizer
  assign m_tvalid_o     = desc_bus.valid;
  assign m_tlast_o      = desc_bus.last;
  assign m_tdata_o      = desc_bus.data;
  assign desc_bus.ready = m_tready_i;

endmodule

/* rtl/usb_ep0_pkg.sv */
package usb_ep0_pkg;

  // Decoded standard request
  typedef enum logic [2:0] {
    REQ_NONE,
    REQ_GET_DEV,
    REQ_SET_ADDR,
    REQ_GET_CONF,
    REQ_SET_CONF,
    REQ_GET_STR
  } req_kind_e;

  // Control pipe states
  typedef enum logic [1:0] {
    PIPE_IDLE,
    PIPE_GET_DESC,
    PIPE_SET_ADDR,
    PIPE_SET_CONF
  } pipe_state_e;

  // bmRequestType fields
  localparam logic [1:0] REQ_TYPE_STANDARD = 2'b00;
  localparam logic [4:0] REQ_RCPT_DEVICE   = 5'b00000;

  // bRequest codes
  localparam logic [7:0] REQ_CODE_SET_ADDRESS       = 8'd5;
  localparam logic [7:0] REQ_CODE_GET_DESCRIPTOR    = 8'd6;
  localparam logic [7:0] REQ_CODE_SET_CONFIGURATION = 8'd9;

  // Descriptor types in the high byte of wValue
  localparam logic [7:0] DESC_TYPE_DEVICE = 8'd1;
  localparam logic [7:0] DESC_TYPE_CONFIG = 8'd2;
  localparam logic [7:0] DESC_TYPE_STRING = 8'd3;

  localparam int DESC_ROM_SIZE = 62;
  localparam int DESC_ADDR_W   = 6;
  localparam int NUM_STRINGS   = 4;

  // Slice offsets into the ROM
  localparam logic [DESC_ADDR_W-1:0] DESC_START_DEV  = 6'd0;
  localparam logic [DESC_ADDR_W-1:0] DESC_START_CONF = 6'd18;
  localparam logic [DESC_ADDR_W-1:0] DESC_START_STR0 = 6'd36;
  localparam logic [DESC_ADDR_W-1:0] DESC_START_STR1 = 6'd40;
  localparam logic [DESC_ADDR_W-1:0] DESC_START_STR2 = 6'd48;
  localparam logic [DESC_ADDR_W-1:0] DESC_START_STR3 = 6'd56;

  // Slice lengths in bytes
  localparam logic [7:0] DESC_LEN_DEV  = 8'd18;
  localparam logic [7:0] DESC_LEN_CONF = 8'd18;
  localparam logic [7:0] DESC_LEN_STR0 = 8'd4;
  localparam logic [7:0] DESC_LEN_STR1 = 8'd8;
  localparam logic [7:0] DESC_LEN_STR2 = 8'd8;
  localparam logic [7:0] DESC_LEN_STR3 = 8'd6;

  // All multi-byte fields are little endian, as sent on the bus
  localparam logic [7:0] DESC_ROM [DESC_ROM_SIZE] = '{
    // Device descriptor, USB 2.0, vendor-specific class
    8'h12, 8'h01, 8'h00, 8'h02,
    8'hFF, 8'h00, 8'h00, 8'h40,
    // idVendor, idProduct, bcdDevice
    8'hCE, 8'hFA, 8'hDE, 8'h0B,
    8'h00, 8'h00,
    // String indices and one configuration
    8'h01, 8'h02, 8'h03, 8'h01,
    // Configuration descriptor, wTotalLength 18, self-powered, 100 mA
    8'h09, 8'h02, 8'h12, 8'h00,
    8'h01, 8'h01, 8'h00, 8'hC0,
    8'h32,
    // Interface 0 with no endpoints
    8'h09, 8'h04, 8'h00, 8'h00,
    8'h00, 8'h00, 8'h00, 8'h00,
    8'h00,
    // String 0, language list with US English only
    8'h04, 8'h03, 8'h09, 8'h04,
    // Manufacturer "Fab"
    8'h08, 8'h03, 8'h46, 8'h00,
    8'h61, 8'h00, 8'h62, 8'h00,
    // Product "Ep0"
    8'h08, 8'h03, 8'h45, 8'h00,
    8'h70, 8'h00, 8'h30, 8'h00,
    // Serial "01"
    8'h06, 8'h03, 8'h30, 8'h00,
    8'h31, 8'h00
  };

endpackage

/* test/tb_clock_gen.sv */
`timescale 1ns/1ps

// Free-running testbench clock and power-on reset
module tb_clock_gen (
  output logic clock_o,
  output logic reset_o
);

  localparam int HALF_PERIOD  = 2;
  localparam int RESET_CYCLES = 8;

  initial begin
    clock_o = 1'b0;
    forever #HALF_PERIOD clock_o = ~clock_o;
  end

  initial begin
    reset_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clock_o);
    reset_o <= 1'b0;
  end

endmodule

/* test/usb_ep0_ctrl_tb.sv */
`timescale 1ns/1ps

module usb_ep0_ctrl_tb;

  localparam int          NUM_TESTS      = 14;
  localparam int          RESET_CYCLES   = 8;
  localparam int          TIMEOUT_CYCLES = NUM_TESTS * 200 + RESET_CYCLES;
  localparam int          WAIT_LIMIT     = 20;
  localparam int          STALL_LIMIT    = 40;
  localparam int          QUIET_CYCLES   = 4;
  localparam int unsigned RAND_SEED      = 32'h373a8eb0;

  logic       clock;
  logic       reset;
  logic       setup_valid_i;
  logic [7:0] setup_data_i;
  logic       select_i;
  logic       accept_o;
  logic       error_o;
  logic       configured_o;
  logic [6:0] usb_addr_o;
  logic [7:0] usb_conf_o;
  logic       m_tvalid_o;
  logic       m_tready_i;
  logic       m_tlast_o;
  logic [7:0] m_tdata_o;

  int error_count = 0;
  int pass_count  = 0;
  int fail_count  = 0;
  int cycle_count = 0;
  int row_count   = 0;

  // Request table, one entry per test
  string       row_name   [NUM_TESTS];
  logic [63:0] row_setup  [NUM_TESTS];
  logic        row_accept [NUM_TESTS];
  logic [6:0]  row_addr   [NUM_TESTS];
  logic [7:0]  row_conf   [NUM_TESTS];
  int          row_start  [NUM_TESTS];
  int          row_len    [NUM_TESTS];

  // Expected descriptor bytes: device, configuration, then strings 0 to 3
  logic [7:0] rom_bytes [62] = '{
    8'h12, 8'h01, 8'h00, 8'h02, 8'hFF, 8'h00, 8'h00, 8'h40,
    8'hCE, 8'hFA, 8'hDE, 8'h0B, 8'h00, 8'h00, 8'h01, 8'h02,
    8'h03, 8'h01, 8'h09, 8'h02, 8'h12, 8'h00, 8'h01, 8'h01,
    8'h00, 8'hC0, 8'h32, 8'h09, 8'h04, 8'h00, 8'h00, 8'h00,
    8'h00, 8'h00, 8'h00, 8'h00, 8'h04, 8'h03, 8'h09, 8'h04,
    8'h08, 8'h03, 8'h46, 8'h00, 8'h61, 8'h00, 8'h62, 8'h00,
    8'h08, 8'h03, 8'h45, 8'h00, 8'h70, 8'h00, 8'h30, 8'h00,
    8'h06, 8'h03, 8'h30, 8'h00, 8'h31, 8'h00
  };

  tb_clock_gen clock_gen_i (
    .clock_o(clock),
    .reset_o(reset)
  );

  usb_ep0_ctrl dut_i (
    .clock        (clock),
    .reset        (reset),
    .setup_valid_i(setup_valid_i),
    .setup_data_i (setup_data_i),
    .select_i     (select_i),
    .accept_o     (accept_o),
    .error_o      (error_o),
    .configured_o (configured_o),
    .usb_addr_o   (usb_addr_o),
    .usb_conf_o   (usb_conf_o),
    .m_tvalid_o   (m_tvalid_o),
    .m_tready_i   (m_tready_i),
    .m_tlast_o    (m_tlast_o),
    .m_tdata_o    (m_tdata_o)
  );

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the run did not complete", cycle_count);
      $display("Finished with errors");
      $finish;
    end
  end

  task automatic check_verdict(input string name, input logic exp_acc, input logic exp_err,
                               input logic act_acc, input logic act_err);
    if (act_acc !== exp_acc || act_err !== exp_err) begin
      $display("[FAIL] %s verdict: expected accept=%b error=%b, actual accept=%b error=%b",
               name, exp_acc, exp_err, act_acc, act_err);
      error_count++;
    end
  endtask

  task automatic check_byte(input string name, input int idx, input logic [7:0] exp_data,
                            input logic [7:0] act_data);
    if (act_data !== exp_data) begin
      $display("[FAIL] %s byte %0d: expected 0x%02h, actual 0x%02h",
               name, idx, exp_data, act_data);
      error_count++;
    end
  endtask

  task automatic check_addr(input string name, input logic [6:0] exp_addr,
                            input logic [6:0] act_addr);
    if (act_addr !== exp_addr) begin
      $display("[FAIL] %s address: expected 0x%02h, actual 0x%02h", name, exp_addr, act_addr);
      error_count++;
    end
  endtask

  task automatic check_conf(input string name, input logic [7:0] exp_conf,
                            input logic [7:0] act_conf, input logic exp_cfgd,
                            input logic act_cfgd);
    if (act_conf !== exp_conf || act_cfgd !== exp_cfgd) begin
      $display("[FAIL] %s configuration: expected %0d configured=%b, actual %0d configured=%b",
               name, exp_conf, exp_cfgd, act_conf, act_cfgd);
      error_count++;
    end
  endtask

  task automatic check_count(input string name, input int exp_count, input int act_count,
                             input int exp_last, input int act_last);
    if (act_count != exp_count || act_last != exp_last) begin
      $display("[FAIL] %s stream: expected %0d bytes last at %0d, actual %0d bytes last at %0d",
               name, exp_count, exp_last, act_count, act_last);
      error_count++;
    end
  endtask

  // SETUP bytes in wire order, wIndex left at zero
  task automatic add_row(input string name, input logic [7:0] req_type,
                         input logic [7:0] code, input logic [15:0] value,
                         input logic [15:0] length, input logic accept,
                         input logic [6:0] addr, input logic [7:0] conf,
                         input int start, input int len);
    row_name[row_count]   = name;
    row_setup[row_count]  = {length, 16'h0000, value, code, req_type};
    row_accept[row_count] = accept;
    row_addr[row_count]   = addr;
    row_conf[row_count]   = conf;
    row_start[row_count]  = start;
    row_len[row_count]    = len;
    row_count++;
  endtask

  task automatic build_table();
    add_row("get_dev_64", 8'h80, usb_ep0_pkg::REQ_CODE_GET_DESCRIPTOR, 16'h0100, 16'd64,
            1'b1, 7'h00, 8'h00, 0, 18);
    add_row("get_dev_8", 8'h80, usb_ep0_pkg::REQ_CODE_GET_DESCRIPTOR, 16'h0100, 16'd8,
            1'b1, 7'h00, 8'h00, 0, 8);
    add_row("get_conf", 8'h80, usb_ep0_pkg::REQ_CODE_GET_DESCRIPTOR, 16'h0200, 16'd255,
            1'b1, 7'h00, 8'h00, 18, 18);
    add_row("get_str0", 8'h80, usb_ep0_pkg::REQ_CODE_GET_DESCRIPTOR, 16'h0300, 16'd255,
            1'b1, 7'h00, 8'h00, 36, 4);
    add_row("get_str1", 8'h80, usb_ep0_pkg::REQ_CODE_GET_DESCRIPTOR, 16'h0301, 16'd255,
            1'b1, 7'h00, 8'h00, 40, 8);
    add_row("get_str2", 8'h80, usb_ep0_pkg::REQ_CODE_GET_DESCRIPTOR, 16'h0302, 16'd255,
            1'b1, 7'h00, 8'h00, 48, 8);
    add_row("get_str3", 8'h80, usb_ep0_pkg::REQ_CODE_GET_DESCRIPTOR, 16'h0303, 16'd255,
            1'b1, 7'h00, 8'h00, 56, 6);
    add_row("get_str4", 8'h80, usb_ep0_pkg::REQ_CODE_GET_DESCRIPTOR, 16'h0304, 16'd255,
            1'b0, 7'h00, 8'h00, 0, 0);
    add_row("set_addr", 8'h00, usb_ep0_pkg::REQ_CODE_SET_ADDRESS, 16'h002A, 16'd0,
            1'b1, 7'h2A, 8'h00, 0, 0);
    add_row("set_conf", 8'h00, usb_ep0_pkg::REQ_CODE_SET_CONFIGURATION, 16'h0001, 16'd0,
            1'b1, 7'h2A, 8'h01, 0, 0);
    // Class request that reuses the SET_CONFIGURATION code
    add_row("class_req", 8'h21, usb_ep0_pkg::REQ_CODE_SET_CONFIGURATION, 16'h0002, 16'd0,
            1'b0, 7'h2A, 8'h01, 0, 0);
    add_row("iface_rcpt", 8'h01, usb_ep0_pkg::REQ_CODE_SET_ADDRESS, 16'h0033, 16'd0,
            1'b0, 7'h2A, 8'h01, 0, 0);
    add_row("unknown_req", 8'h00, 8'h07, 16'h0100, 16'd0,
            1'b0, 7'h2A, 8'h01, 0, 0);
    add_row("get_dev_zero", 8'h80, usb_ep0_pkg::REQ_CODE_GET_DESCRIPTOR, 16'h0100, 16'd0,
            1'b1, 7'h2A, 8'h01, 0, 0);
  endtask

  task automatic send_setup(input logic [63:0] pkt);
    for (int b = 0; b < 8; b++) begin
      @(posedge clock);
      setup_valid_i <= 1'b1;
      setup_data_i  <= pkt[8*b +: 8];
    end
    @(posedge clock);
    setup_valid_i <= 1'b0;
  endtask

  task automatic wait_verdict(input string name, output bit got);
    int cycles;
    cycles = 0;
    got    = 1'b0;
    while (!got && cycles < WAIT_LIMIT) begin
      @(negedge clock);
      if (accept_o || error_o) begin
        got = 1'b1;
      end else begin
        cycles++;
      end
    end
    if (!got) begin
      $display("%s: neither accept_o nor error_o rose after the SETUP packet", name);
      error_count++;
    end
  endtask

  // Ready toggles randomly, outputs are sampled on the falling edge
  task automatic collect_stream(input string name, input int start, input int len);
    int count;
    int last_pos;
    int stall;
    bit done;
    count    = 0;
    last_pos = -1;
    stall    = 0;
    done     = 1'b0;
    while (!done) begin
      @(posedge clock);
      m_tready_i <= ($urandom % 2) != 0;
      @(negedge clock);
      if (m_tvalid_o && m_tready_i) begin
        stall = 0;
        if (count >= len) begin
          $display("%s: the DUT sent more than the %0d bytes expected", name, len);
          error_count++;
          done = 1'b1;
        end else begin
          check_byte(name, count, rom_bytes[start + count], m_tdata_o);
          if (m_tlast_o) begin
            last_pos = count;
            done     = 1'b1;
          end
          count++;
        end
      end else begin
        stall++;
        if (len == 0 && stall >= QUIET_CYCLES) begin
          done = 1'b1;
        end else if (stall >= STALL_LIMIT) begin
          if (count == 0) begin
            $display("%s: the descriptor stream never started", name);
          end else begin
            $display("%s: the descriptor stream never ended after %0d bytes", name, count);
          end
          error_count++;
          done = 1'b1;
        end
      end
    end
    @(posedge clock);
    m_tready_i <= 1'b0;
    @(negedge clock);
    if (m_tvalid_o) begin
      $display("%s: m_tvalid_o is still high after the end of the stream", name);
      error_count++;
    end
    check_count(name, len, count, len - 1, last_pos);
  endtask

  task automatic release_select(input string name);
    @(posedge clock);
    select_i   <= 1'b0;
    m_tready_i <= 1'b0;
    @(posedge clock);
    @(negedge clock);
    check_verdict({name, " release"}, 1'b0, 1'b0, accept_o, error_o);
  endtask

  task automatic report_test(input string name, input int errors_before);
    if (error_count == errors_before) begin
      pass_count++;
      $display("%s passed", name);
    end else begin
      fail_count++;
      $display("%s failed with %0d errors", name, error_count - errors_before);
    end
  endtask

  task automatic run_row(input int idx);
    int    errors_before;
    bit    got;
    string name;
    name          = row_name[idx];
    errors_before = error_count;
    @(posedge clock);
    select_i <= 1'b1;
    send_setup(row_setup[idx]);
    wait_verdict(name, got);
    if (got) begin
      check_verdict(name, row_accept[idx], !row_accept[idx], accept_o, error_o);
      check_addr(name, row_addr[idx], usb_addr_o);
      check_conf(name, row_conf[idx], usb_conf_o, row_conf[idx] != 8'd0, configured_o);
      collect_stream(name, row_start[idx], row_len[idx]);
    end
    release_select(name);
    report_test(name, errors_before);
  endtask

  initial begin
    int unsigned seed_value;
    int          errors_before;
    seed_value    = $urandom(RAND_SEED);
    setup_valid_i = 1'b0;
    setup_data_i  = 8'h00;
    select_i      = 1'b0;
    m_tready_i    = 1'b0;
    build_table();

    @(negedge clock);
    while (reset) begin
      @(negedge clock);
    end

    // Idle outputs straight after reset
    errors_before = error_count;
    check_verdict("reset", 1'b0, 1'b0, accept_o, error_o);
    check_addr("reset", 7'h00, usb_addr_o);
    check_conf("reset", 8'h00, usb_conf_o, 1'b0, configured_o);
    if (m_tvalid_o !== 1'b0) begin
      $display("[FAIL] reset m_tvalid_o: expected 0, actual %b", m_tvalid_o);
      error_count++;
    end
    report_test("reset", errors_before);

    for (int i = 0; i < row_count; i++) begin
      run_row(i);
    end

    $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
    if (error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* usb_ep0_ctrl.f */
rtl/usb_ep0_pkg.sv
rtl/setup_req_if.sv
rtl/desc_stream_if.sv
rtl/setup_packet_capture.sv
rtl/descriptor_reader.sv
rtl/ep0_request_handler.sv
rtl/usb_ep0_ctrl.sv
test/tb_clock_gen.sv
test/usb_ep0_ctrl_tb.sv
